// ==== src.f ====
core_pkg.sv
pipe_pkg.sv
regfile.sv
fetch.sv
decode.sv
execute.sv
memory.sv
hazard.sv
forward.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_cpu -f src.f -o tb_cpu

run: compile
	./obj_dir/tb_cpu | awk '{print} /^All checks passed$$/{ok=1} END{exit !ok}'

clean:
	rm -rf obj_dir

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import core_pkg::*, pipe_pkg::*; ();
    localparam int    N_TESTS = 6;
    localparam inst_t HALT    = 32'h0000_0063;  // beq x0,x0,0.

    logic      clk;
    logic      reset;
    word_t     imem_addr, dmem_addr, dmem_wdata, dmem_rdata, retire_data;
    inst_t     imem_data;
    logic      dmem_we, dmem_re, retire_valid;
    reg_addr_t retire_rd;
    int        error_count, check_count;

    inst_t imem [128];
    word_t dmem [64];
    inst_t progs [N_TESTS][16];
    word_t expect_x10 [N_TESTS];
    string names [N_TESTS];
    word_t last_x10;
    int    fails;
    logic [31:0] seed;

    assign imem_data  = imem[imem_addr[8:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    cpu DUT (.*);

    cpu_checker model_check (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            last_x10 <= 'x;                    // nothing retired to x10 yet.
            for (int i = 0; i < 64; i++) dmem[i] <= '0;
        end else begin
            if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
            if (retire_valid && retire_rd == 5'd10) last_x10 <= retire_data;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic inst_t alu_rr(funct7_t f7, funct3_t f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_ALU};
    endfunction

    function automatic inst_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, F3_ADD, rd, OP_ALUI};
    endfunction

    function automatic inst_t sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_W, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t branch(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    // random alu row with its x10 worked out from the isa rules.
    task automatic make_random_row(input int t);
        word_t       r [6];
        logic [31:0] x;
        reg_addr_t   rd, s1, s2;
        for (int i = 0; i < 6; i++) r[i] = '0;
        for (int i = 1; i < 6; i++) begin          // seed x1..x5.
            seed = xorshift(seed);
            progs[t][i-1] = addi(reg_addr_t'(i), 5'd0, seed[31:20]);
            r[i] = {{20{seed[31]}}, seed[31:20]};
        end
        for (int i = 5; i < 16; i++) begin
            seed = xorshift(seed);
            x    = seed;
            rd   = (i == 15) ? 5'd10 : reg_addr_t'(1 + x[2:0] % 5);
            s1   = reg_addr_t'(x[5:3] % 6);
            s2   = reg_addr_t'(x[8:6] % 6);
            case ((i == 15) ? 0 : x[11:9] % 6)
                0: progs[t][i] = alu_rr(F7_BASE, F3_ADD, rd, s1, s2);
                1: progs[t][i] = alu_rr(F7_SUB, F3_ADD, rd, s1, s2);
                2: progs[t][i] = alu_rr(F7_BASE, F3_AND, rd, s1, s2);
                3: progs[t][i] = alu_rr(F7_BASE, F3_OR, rd, s1, s2);
                4: progs[t][i] = alu_rr(F7_BASE, F3_XOR, rd, s1, s2);
                default: progs[t][i] = addi(rd, s1, x[31:20]);
            endcase
            case ((i == 15) ? 0 : x[11:9] % 6)
                0: x = r[s1] + r[s2];
                1: x = r[s1] - r[s2];
                2: x = r[s1] & r[s2];
                3: x = r[s1] | r[s2];
                4: x = r[s1] ^ r[s2];
                default: x = r[s1] + {{20{x[31]}}, x[31:20]};
            endcase
            if (rd != 5'd10) r[rd] = x;
            else expect_x10[t] = x;
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < N_TESTS; t++) begin
            for (int i = 0; i < 16; i++) progs[t][i] = HALT;
        end
        names[0] = "forward chain";
        progs[0][0] = addi(5'd1, 5'd0, 12'd5);
        progs[0][1] = addi(5'd2, 5'd0, 12'd3);
        progs[0][2] = alu_rr(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2);   // 8.
        progs[0][3] = alu_rr(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1);    // 3.
        progs[0][4] = alu_rr(F7_BASE, F3_OR, 5'd5, 5'd3, 5'd4);    // 11.
        progs[0][5] = alu_rr(F7_BASE, F3_XOR, 5'd6, 5'd5, 5'd1);   // 14.
        progs[0][6] = alu_rr(F7_BASE, F3_AND, 5'd7, 5'd6, 5'd5);   // 10.
        progs[0][7] = alu_rr(F7_BASE, F3_ADD, 5'd10, 5'd7, 5'd6);  // 24.
        progs[0][8] = addi(5'd10, 5'd10, 12'd1);
        expect_x10[0] = 32'd25;
        names[1] = "store load use";
        progs[1][0] = addi(5'd1, 5'd0, 12'd7);
        progs[1][1] = addi(5'd2, 5'd0, 12'h40);
        progs[1][2] = sw(5'd1, 5'd2, 12'd4);
        progs[1][3] = {12'd4, 5'd2, F3_W, 5'd3, OP_LOAD};          // lw x3,4(x2).
        progs[1][4] = alu_rr(F7_BASE, F3_ADD, 5'd10, 5'd3, 5'd1);
        expect_x10[1] = 32'd14;
        names[2] = "branches";
        progs[2][0] = addi(5'd10, 5'd0, 12'd1);
        progs[2][1] = branch(F3_BEQ, 5'd0, 5'd0, 13'd12);           // skips two.
        progs[2][2] = addi(5'd10, 5'd0, 12'd2);
        progs[2][3] = addi(5'd10, 5'd0, 12'd3);
        progs[2][4] = branch(F3_BNE, 5'd0, 5'd0, 13'd8);            // falls through.
        progs[2][5] = addi(5'd10, 5'd10, 12'd4);
        expect_x10[2] = 32'd5;
        names[3] = "illegal trap";
        progs[3][0] = addi(5'd10, 5'd0, 12'd1);
        progs[3][1] = 32'hffff_ffff;
        progs[3][2] = addi(5'd10, 5'd0, 12'd9);                    // must not retire.
        expect_x10[3] = 32'h56;                                    // handler adds 0x55.
        names[4] = "x0 and lui";
        progs[4][0] = addi(5'd0, 5'd0, 12'd5);
        progs[4][1] = alu_rr(F7_BASE, F3_OR, 5'd0, 5'd0, 5'd0);
        progs[4][2] = {20'habcde, 5'd10, OP_LUI};
        progs[4][3] = alu_rr(F7_BASE, F3_ADD, 5'd10, 5'd10, 5'd0);
        progs[4][4] = addi(5'd10, 5'd10, 12'h123);
        expect_x10[4] = 32'habcd_e123;
        names[5] = "random alu";
        make_random_row(5);
    endtask

    task automatic run_test(input int t);
        int err_before;
        err_before = error_count;
        for (int i = 0; i < 128; i++) imem[i] = HALT;
        for (int i = 0; i < 16; i++) imem[i] = progs[t][i];
        imem[64] = addi(5'd10, 5'd10, 12'h55);                     // trap handler.
        @(posedge clk);
        #1 reset = 1'b1;                                           // also clears dmem.
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (imem_data != HALT);
        repeat (8) @(posedge clk);
        #1;
        if (last_x10 !== expect_x10[t] || error_count != err_before) begin
            $display("FAIL %0t: test %s, x10=%h, expected %h", $time, names[t],
                     last_x10, expect_x10[t]);
            fails++;
        end else begin
            $display("PASS test %s", names[t]);
        end
    endtask

    initial begin
        #(N_TESTS * 200 * 10);
        $display("run hung, watchdog stopped the simulation");
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        fails = 0;
        seed  = 32'h5c22ddd8;
        build_table();
        for (int t = 0; t < N_TESTS; t++) run_test(t);
        $display("tests %0d, failed %0d, checker errors %0d of %0d checks",
                 N_TESTS, fails, error_count, check_count);
        if (fails == 0 && error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  inst_t     imem [128],      // same program the DUT runs.
    input  logic      retire_valid,
    input  reg_addr_t retire_rd,
    input  word_t     retire_data,
    input  logic      dmem_we,
    input  logic      dmem_re,
    input  word_t     dmem_addr,
    input  word_t     dmem_wdata,
    output int        error_count,
    output int        check_count
);
    word_t mpc;                        // model program counter.
    word_t regs [32];
    word_t mdmem [64];
    logic  re_q;                       // read strobe of the op now retiring.

    // run the model until the next instruction that shows up outside.
    // kind 1 is a register write, kind 2 a store, kind 3 a load write.
    task automatic step_model(output int kind, output reg_addr_t rd, output word_t val,
                              output word_t addr);
        inst_t     in;
        opcode_t   op;
        funct3_t   f3;
        funct7_t   f7;
        reg_addr_t d;
        word_t     a, b, imm_i, imm_s, imm_b, res, next;
        logic      wr;
        logic      ld;
        kind = 0;
        rd   = '0;
        val  = '0;
        addr = '0;
        for (int n = 0; n < 64 && kind == 0; n++) begin
            in    = imem[mpc[8:2]];
            op    = in[6:0];
            f3    = in[14:12];
            f7    = in[31:25];
            d     = in[11:7];
            a     = regs[in[19:15]];
            b     = regs[in[24:20]];
            imm_i = {{20{in[31]}}, in[31:20]};
            imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
            imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
            next  = mpc + 32'd4;
            wr    = 1'b0;
            ld    = 1'b0;
            res   = '0;
            if (op == OP_ALU && f7 == F7_SUB && f3 == F3_ADD) begin
                res = a - b;
                wr  = 1'b1;
            end else if (op == OP_ALU && f7 == F7_BASE && f3 == F3_ADD) begin
                res = a + b;
                wr  = 1'b1;
            end else if (op == OP_ALU && f7 == F7_BASE && f3 == F3_XOR) begin
                res = a ^ b;
                wr  = 1'b1;
            end else if (op == OP_ALU && f7 == F7_BASE && f3 == F3_OR) begin
                res = a | b;
                wr  = 1'b1;
            end else if (op == OP_ALU && f7 == F7_BASE && f3 == F3_AND) begin
                res = a & b;
                wr  = 1'b1;
            end else if (op == OP_ALUI && f3 == F3_ADD) begin
                res = a + imm_i;
                wr  = 1'b1;
            end else if (op == OP_LUI) begin
                res = {in[31:12], 12'h000};
                wr  = 1'b1;
            end else if (op == OP_LOAD && f3 == F3_W) begin
                res = mdmem[6'((a + imm_i) >> 2)];   // word index, wraps in 64.
                wr  = 1'b1;
                ld  = 1'b1;
            end else if (op == OP_STORE && f3 == F3_W) begin
                addr = a + imm_s;
                mdmem[addr[7:2]] = b;
                val  = b;
                kind = 2;
            end else if (op == OP_BRANCH && (f3 == F3_BEQ || f3 == F3_BNE)) begin
                if ((a == b) != f3[0]) begin
                    next = mpc + imm_b;          // taken.
                end
            end else begin
                next = TRAP_BASE;                // illegal encoding.
            end
            if (wr && d != '0) begin
                regs[d] = res;
                kind    = ld ? 3 : 1;
                rd      = d;
                val     = res;
            end
            mpc = next;
        end
    endtask

    always @(posedge clk) begin
        int        kind;
        reg_addr_t rd;
        word_t     val, addr;
        if (reset) begin
            mpc  = RESET_BASE;
            re_q = 1'b0;
            for (int i = 0; i < 32; i++) regs[i] = '0;
            for (int i = 0; i < 64; i++) mdmem[i] = '0;
        end else begin
            // the retiring op is older than the store in memory.
            if (retire_valid) begin
                step_model(kind, rd, val, addr);
                check_count++;
                if (kind != 1 && kind != 3) begin
                    $display("FAIL %0t: retire of x%0d with no register write due", $time,
                             retire_rd);
                    error_count++;
                end else if (retire_rd !== rd || retire_data !== val) begin
                    $display("FAIL %0t: retire x%0d=%h, expected x%0d=%h", $time,
                             retire_rd, retire_data, rd, val);
                    error_count++;
                end else if ((kind == 3) != re_q) begin
                    $display("FAIL %0t: data read strobe %b for retire of x%0d", $time,
                             re_q, rd);
                    error_count++;
                end
            end
            if (dmem_we) begin
                step_model(kind, rd, val, addr);
                check_count++;
                if (kind != 2) begin
                    $display("FAIL %0t: store seen where none was due", $time);
                    error_count++;
                end else if (dmem_addr !== addr || dmem_wdata !== val) begin
                    $display("FAIL %0t: store %h to %h, expected %h to %h", $time,
                             dmem_wdata, dmem_addr, val, addr);
                    error_count++;
                end
            end
            re_q = dmem_re;            // op in memory retires next cycle.
        end
    end

    initial begin
        error_count = 0;
        check_count = 0;
        mpc         = RESET_BASE;
    end

endmodule

`default_nettype wire

// ==== cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import core_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  inst_t     imem_data,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    input  word_t     dmem_rdata,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    // IF/ID.
    logic      if_valid;
    word_t     if_pc;
    inst_t     if_inst;

    // decode side and control.
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    fwd_t      rs1_sel, rs2_sel;
    logic      uses_rs2, invalid, bubble;

    // ID/EX.
    logic      id_valid, id_mem_re, id_mem_we, id_is_branch, id_branch_ne;
    word_t     id_pc, id_a, id_b, id_store, id_imm;
    alu_op_t   id_alu_op;
    reg_addr_t id_rd;
    wb_src_t   id_wb_src;

    // execute outputs and EX/MEM.
    word_t     alu_result, branch_target;
    logic      branch_taken;
    logic      ex_valid, ex_rd_en, ex_mem_re, ex_mem_we;
    word_t     ex_result, ex_store;
    reg_addr_t ex_rd;
    wb_src_t   ex_wb_src;
    word_t     wb_data;  // result of the op in memory.

    fetch fetch (.*);

    // the op right ahead forwards straight from the ALU.
    decode decode (.ex_result(alu_result), .*);

    // MEM/WB register is the write port.
    regfile regfile (.rd_en(retire_valid), .rd_addr(retire_rd), .rd_data(retire_data), .*);

    execute execute (.*);

    memory memory (.*);

    hazard hazard (.id_ex_mem_re(id_mem_re), .id_ex_rd(id_rd), .*);

    forward forward (
        .ex_rd_en(id_valid),  // op in execute.
        .ex_rd(id_rd),
        .ex_is_load(id_mem_re),
        .wb_rd_en(ex_rd_en),  // op in memory.
        .wb_rd(ex_rd),
        .*
    );

endmodule

`default_nettype wire

// ==== forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward import core_pkg::*, pipe_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      ex_rd_en,
    input  reg_addr_t ex_rd,
    input  logic      ex_is_load,
    input  logic      wb_rd_en,
    input  reg_addr_t wb_rd,
    output fwd_t      rs1_sel,
    output fwd_t      rs2_sel
);
    function automatic fwd_t pick(input reg_addr_t rs);
        if (rs == '0) begin
            return FWD_REG;            // x0 never forwarded.
        end
        if (ex_rd_en && !ex_is_load && ex_rd == rs) begin
            return FWD_EX;             // youngest producer wins.
        end
        if (wb_rd_en && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        rs1_sel = pick(rs1_addr);
        rs2_sel = pick(rs2_addr);
    end

endmodule

`default_nettype wire

// ==== hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard import core_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      uses_rs2,
    input  logic      id_ex_mem_re,
    input  reg_addr_t id_ex_rd,
    output logic      bubble
);
    logic hit_rs1;
    logic hit_rs2;

    assign hit_rs1 = (id_ex_rd == rs1_addr);
    assign hit_rs2 = uses_rs2 && (id_ex_rd == rs2_addr);

    // load data is one stage late for the op right behind it.
    assign bubble = id_ex_mem_re && (id_ex_rd != '0) && (hit_rs1 || hit_rs2);

endmodule

`default_nettype wire

// ==== memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory import core_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  word_t     ex_result,
    input  word_t     ex_store,
    input  reg_addr_t ex_rd,
    input  logic      ex_rd_en,
    input  wb_src_t   ex_wb_src,
    input  logic      ex_mem_re,
    input  logic      ex_mem_we,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    input  word_t     dmem_rdata,
    output word_t     wb_data,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    assign dmem_addr  = ex_result;            // ALU computed address.
    assign dmem_wdata = ex_store;
    assign dmem_re    = ex_valid && ex_mem_re;
    assign dmem_we    = ex_valid && ex_mem_we;

    // load data arrives in the same cycle.
    assign wb_data = (ex_wb_src == WB_MEM) ? dmem_rdata : ex_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_rd_en;          // already clear for x0.
        end
    end

    always_ff @(posedge clk) begin
        retire_rd   <= ex_rd;
        retire_data <= wb_data;
    end

    a_dmem_excl: assert property (@(posedge clk) disable iff (reset)
        !(dmem_we && dmem_re))
        else $error("data memory read and write in one cycle");

endmodule

`default_nettype wire

// ==== execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import core_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      id_valid,
    input  word_t     id_pc,
    input  alu_op_t   id_alu_op,
    input  word_t     id_a,
    input  word_t     id_b,
    input  word_t     id_store,
    input  reg_addr_t id_rd,
    input  wb_src_t   id_wb_src,
    input  logic      id_mem_re,
    input  logic      id_mem_we,
    input  logic      id_is_branch,
    input  logic      id_branch_ne,
    input  word_t     id_imm,
    output word_t     alu_result,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      ex_valid,
    output word_t     ex_result,
    output word_t     ex_store,
    output reg_addr_t ex_rd,
    output logic      ex_rd_en,
    output wb_src_t   ex_wb_src,
    output logic      ex_mem_re,
    output logic      ex_mem_we
);
    logic equal;

    always_comb begin
        case (id_alu_op)
            ALU_SUB:    alu_result = id_a - id_b;
            ALU_AND:    alu_result = id_a & id_b;
            ALU_OR:     alu_result = id_a | id_b;
            ALU_XOR:    alu_result = id_a ^ id_b;
            ALU_PASS_B: alu_result = id_b;
            default:    alu_result = id_a + id_b;  // add and address calc.
        endcase
    end

    assign equal         = (id_a == id_b);
    assign branch_taken  = id_valid && id_is_branch && (equal ^ id_branch_ne);
    assign branch_target = id_pc + id_imm;   // pc-relative.

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            ex_rd_en  <= 1'b0;
            ex_mem_re <= 1'b0;
            ex_mem_we <= 1'b0;
        end else begin
            ex_valid  <= id_valid;
            ex_rd_en  <= id_valid && (id_rd != '0);  // x0 never retires.
            ex_mem_re <= id_valid && id_mem_re;
            ex_mem_we <= id_valid && id_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_result <= alu_result;
            ex_store  <= id_store;
            ex_rd     <= id_rd;
            ex_wb_src <= id_wb_src;
        end
    end

    // taken branch squashes the slot behind it.
    a_branch_flush: assert property (@(posedge clk) disable iff (reset)
        branch_taken |=> !id_valid)
        else $error("slot after taken branch not flushed");

endmodule

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      if_valid,
    input  word_t     if_pc,
    input  inst_t     if_inst,
    input  logic      branch_taken,
    input  logic      bubble,
    input  fwd_t      rs1_sel,
    input  fwd_t      rs2_sel,
    input  word_t     ex_result,
    input  word_t     wb_data,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      uses_rs2,
    output logic      invalid,
    output logic      id_valid,
    output word_t     id_pc,
    output alu_op_t   id_alu_op,
    output word_t     id_a,
    output word_t     id_b,
    output word_t     id_store,
    output reg_addr_t id_rd,
    output wb_src_t   id_wb_src,
    output logic      id_mem_re,
    output logic      id_mem_we,
    output logic      id_is_branch,
    output logic      id_branch_ne,
    output word_t     id_imm
);
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i, imm_s, imm_b, imm_u, imm;
    word_t   rs1_val, rs2_val;
    alu_op_t alu_op;
    wb_src_t wb_src;
    logic    legal, need_rs2, use_imm, writes_rd, mem_re, mem_we, is_branch;
    logic    kill;

    assign opcode = if_inst[6:0];
    assign funct3 = if_inst[14:12];
    assign funct7 = if_inst[31:25];

    assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                    if_inst[11:8], 1'b0};
    assign imm_u = {if_inst[31:12], 12'h000};

    always_comb begin
        legal     = 1'b0;       // anything unlisted traps.
        need_rs2  = 1'b0;
        use_imm   = 1'b1;
        writes_rd = 1'b0;
        mem_re    = 1'b0;
        mem_we    = 1'b0;
        is_branch = 1'b0;
        alu_op    = ALU_ADD;
        wb_src    = WB_ALU;
        imm       = imm_i;
        case (opcode)
            OP_ALU: begin
                need_rs2  = 1'b1;
                use_imm   = 1'b0;
                writes_rd = 1'b1;
                legal     = (funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == F3_ADD);
                case (funct3)
                    F3_ADD:  alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: legal  = 1'b0;
                endcase
            end
            OP_ALUI: begin
                writes_rd = 1'b1;
                legal     = (funct3 == F3_ADD);  // addi only.
            end
            OP_LUI: begin
                writes_rd = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
                legal     = 1'b1;
            end
            OP_LOAD: begin
                writes_rd = 1'b1;
                mem_re    = 1'b1;
                wb_src    = WB_MEM;
                legal     = (funct3 == F3_W);
            end
            OP_STORE: begin
                need_rs2 = 1'b1;       // store data.
                mem_we   = 1'b1;
                imm      = imm_s;
                legal    = (funct3 == F3_W);
            end
            OP_BRANCH: begin
                need_rs2  = 1'b1;
                use_imm   = 1'b0;      // compare rs1 with rs2.
                is_branch = 1'b1;
                imm       = imm_b;
                legal     = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            default: legal = 1'b0;
        endcase
    end

    // empty slots read x0 so they never stall or forward.
    assign rs1_addr = if_valid ? if_inst[19:15] : '0;
    assign rs2_addr = if_inst[24:20];
    assign uses_rs2 = if_valid && need_rs2;

    // a slot behind a taken branch is dead and cannot trap.
    assign invalid = if_valid && !legal && !branch_taken;
    assign kill    = branch_taken || bubble || !if_valid || !legal;

    function automatic word_t pick(input fwd_t sel, input word_t rf, input word_t ex,
                                   input word_t wb);
        case (sel)
            FWD_EX:  return ex;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign rs1_val = pick(rs1_sel, rs1_data, ex_result, wb_data);
    assign rs2_val = pick(rs2_sel, rs2_data, ex_result, wb_data);

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            id_valid     <= 1'b0;  // bubble or flushed slot.
            id_mem_re    <= 1'b0;
            id_mem_we    <= 1'b0;
            id_is_branch <= 1'b0;
        end else begin
            id_valid     <= 1'b1;
            id_mem_re    <= mem_re;
            id_mem_we    <= mem_we;
            id_is_branch <= is_branch;
        end
    end

    always_ff @(posedge clk) begin
        id_pc        <= if_pc;
        id_alu_op    <= alu_op;
        id_a         <= rs1_val;
        id_b         <= use_imm ? imm : rs2_val;
        id_store     <= rs2_val;
        id_rd        <= writes_rd ? if_inst[11:7] : '0;  // x0 means no write.
        id_wb_src    <= wb_src;
        id_branch_ne <= funct3[0];
        id_imm       <= imm;
    end

    // forward selects settle before the operand is used.
    a_sel_known: assert property (@(posedge clk) disable iff (reset)
        if_valid |-> !$isunknown({rs1_sel, rs2_sel}))
        else $error("operand select unknown in decode");

endmodule

`default_nettype wire

// ==== fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch import core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  bubble,
    input  logic  invalid,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t imem_addr,
    input  inst_t imem_data,
    output logic  if_valid,
    output word_t if_pc,
    output inst_t if_inst
);
    word_t pc;
    logic  flush;

    assign imem_addr = pc;                       // read in the same cycle.
    assign flush     = invalid || branch_taken;  // squash the slot being fetched.

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_BASE;
        end else if (invalid) begin
            pc <= TRAP_BASE;           // trap wins over everything.
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!bubble) begin
            pc <= pc + 32'd4;          // held on load-use stall.
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_valid <= 1'b0;
        end else if (!bubble) begin
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!bubble) begin
            if_pc   <= pc;
            if_inst <= imem_data;
        end
    end

    // redirect targets must stay word aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      rd_en,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rd_en && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;                 // x0 hardwired.
        end
        if (rd_en && rd_addr == addr) begin
            return rd_data;            // write lands in the same cycle.
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // operation carried from decode into the ALU.
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,  // add, addi and address calc.
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5   // lui passes the immediate.
    } alu_op_t;

    // operand source picked in decode.
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // register file, incl. its write bypass.
        FWD_EX  = 2'd1,  // ALU output of the op in execute.
        FWD_WB  = 2'd2   // result of the op in memory.
    } fwd_t;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1    // load data.
    } wb_src_t;

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;      // data or address word.
    typedef logic [31:0] inst_t;      // raw instruction word.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [6:0]  opcode_t;    // major opcode field.
    typedef logic [2:0]  funct3_t;    // minor function field.
    typedef logic [6:0]  funct7_t;    // upper function field.

    // major opcodes of the supported subset.
    localparam opcode_t OP_ALU    = 7'b0110011;  // add, sub, and, or, xor.
    localparam opcode_t OP_ALUI   = 7'b0010011;  // addi only.
    localparam opcode_t OP_LUI    = 7'b0110111;  // upper immediate.
    localparam opcode_t OP_LOAD   = 7'b0000011;  // lw only.
    localparam opcode_t OP_STORE  = 7'b0100011;  // sw only.
    localparam opcode_t OP_BRANCH = 7'b1100011;  // beq and bne.

    localparam funct3_t F3_ADD = 3'b000;  // add, sub, addi.
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_W   = 3'b010;  // word size for lw and sw.
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    localparam funct7_t F7_BASE = 7'b0000000;  // plain register op.
    localparam funct7_t F7_SUB  = 7'b0100000;  // selects sub over add.

    localparam word_t RESET_BASE = 32'h0000_0000;  // first fetch.
    localparam word_t TRAP_BASE  = 32'h0000_0100;  // illegal instruction handler.

endpackage

`default_nettype wire
